/* source/debug_pkg.sv */
package debug_pkg;

    ////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////
    localparam int WORD_WIDTH     = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int DUMP_WORDS     = 32;

    // Small baud divider keeps simulation short
    localparam int CLOCKS_PER_BIT = 16;
    localparam int BAUD_LAST      = CLOCKS_PER_BIT - 1;
    localparam int BAUD_HALF      = CLOCKS_PER_BIT / 2 - 1;

    localparam logic [7:0] CMD_MODE_DEBUG = 8'hFF;
    localparam logic [7:0] CMD_MODE_RUN   = 8'h00;
    localparam logic [7:0] CMD_STEP       = 8'hAA;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [BYTE_WIDTH-1:0] uart_byte_t;
    typedef logic [1:0]            byte_index_t;
    typedef logic [4:0]            dump_index_t;
    typedef logic [3:0]            bit_count_t;
    typedef logic [3:0]            baud_count_t;

    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } rx_byte_s;

    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } tx_byte_s;

    typedef struct packed {
        logic  loading;
        word_t instruction;
        word_t address;
    } load_write_s;

    typedef struct packed {
        word_t pc;
        word_t reg_word;
        word_t mem_word;
    } cpu_state_s;

    typedef enum logic [2:0] {
        ST_LOAD,
        ST_MODE,
        ST_DEBUG,
        ST_DUMP_STEP,
        ST_RUN,
        ST_DUMP_FINISH
    } control_state_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_PC,
        PH_REGS,
        PH_MEM
    } dump_phase_e;

    typedef enum logic [1:0] {
        U_IDLE,
        U_START,
        U_DATA,
        U_STOP
    } uart_phase_e;

endpackage

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_rx_data,
    output debug_pkg::rx_byte_s o_rx
);

    logic [1:0]                  sync_q;
    debug_pkg::uart_phase_e      phase_q;
    debug_pkg::baud_count_t      baud_q;
    debug_pkg::bit_count_t       bits_q;
    debug_pkg::uart_byte_t       shift_q;
    logic                        valid_q;
    logic                        line;
    logic                        bit_end;

    assign line    = sync_q[1];
    assign bit_end = baud_q == debug_pkg::baud_count_t'(debug_pkg::BAUD_LAST);
    assign o_rx    = '{valid: valid_q, data: shift_q};

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            sync_q  <= 2'b11;
            phase_q <= debug_pkg::U_IDLE;
            baud_q  <= '0;
            bits_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], i_rx_data};
            valid_q <= 1'b0;
            baud_q  <= baud_q + 1'b1;
            case (phase_q)
                debug_pkg::U_IDLE: begin
                    baud_q <= '0;
                    if (!line) begin
                        phase_q <= debug_pkg::U_START;
                    end
                end
                debug_pkg::U_START: begin
                    // Glitch check in the middle of the start bit
                    if (baud_q == debug_pkg::baud_count_t'(debug_pkg::BAUD_HALF)) begin
                        baud_q  <= '0;
                        bits_q  <= '0;
                        phase_q <= line ? debug_pkg::U_IDLE : debug_pkg::U_DATA;
                    end
                end
                debug_pkg::U_DATA: begin
                    if (bit_end) begin
                        baud_q  <= '0;
                        shift_q <= {line, shift_q[debug_pkg::BYTE_WIDTH-1:1]};
                        bits_q  <= bits_q + 1'b1;
                        if (bits_q == debug_pkg::bit_count_t'(debug_pkg::BYTE_WIDTH - 1)) begin
                            phase_q <= debug_pkg::U_STOP;
                        end
                    end
                end
                debug_pkg::U_STOP: begin
                    // Framing error drops the byte
                    if (bit_end) begin
                        valid_q <= line;
                        phase_q <= debug_pkg::U_IDLE;
                    end
                end
                default: phase_q <= debug_pkg::U_IDLE;
            endcase
        end
    end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                i_clock,
    input  logic                i_reset,
    input  debug_pkg::tx_byte_s i_tx,
    output logic                o_ready,
    output logic                o_tx_data
);

    debug_pkg::uart_phase_e phase_q;
    debug_pkg::baud_count_t baud_q;
    debug_pkg::bit_count_t  bits_q;
    debug_pkg::uart_byte_t  shift_q;
    logic                   line_q;
    logic                   bit_end;

    assign bit_end   = baud_q == debug_pkg::baud_count_t'(debug_pkg::BAUD_LAST);
    assign o_ready   = phase_q == debug_pkg::U_IDLE;
    assign o_tx_data = line_q;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase_q <= debug_pkg::U_IDLE;
            baud_q  <= '0;
            bits_q  <= '0;
            line_q  <= 1'b1;
        end else begin
            baud_q <= bit_end ? '0 : baud_q + 1'b1;
            case (phase_q)
                debug_pkg::U_IDLE: begin
                    baud_q <= '0;
                    if (i_tx.valid) begin
                        shift_q <= i_tx.data;
                        line_q  <= 1'b0;
                        phase_q <= debug_pkg::U_START;
                    end
                end
                debug_pkg::U_START: begin
                    if (bit_end) begin
                        line_q  <= shift_q[0];
                        shift_q <= shift_q >> 1;
                        bits_q  <= '0;
                        phase_q <= debug_pkg::U_DATA;
                    end
                end
                debug_pkg::U_DATA: begin
                    if (bit_end) begin
                        if (bits_q == debug_pkg::bit_count_t'(debug_pkg::BYTE_WIDTH - 1)) begin
                            line_q  <= 1'b1;
                            phase_q <= debug_pkg::U_STOP;
                        end else begin
                            line_q  <= shift_q[0];
                            shift_q <= shift_q >> 1;
                            bits_q  <= bits_q + 1'b1;
                        end
                    end
                end
                debug_pkg::U_STOP: begin
                    if (bit_end) begin
                        phase_q <= debug_pkg::U_IDLE;
                    end
                end
                default: phase_q <= debug_pkg::U_IDLE;
            endcase
        end
    end

    // Sender must wait for ready
    a_no_push_when_busy: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx.valid |-> o_ready);

endmodule

/* source/program_loader.sv */
`timescale 1ns/1ps

module program_loader (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_enable,
    input  debug_pkg::rx_byte_s    i_rx,
    output debug_pkg::load_write_s o_write,
    output logic                   o_program_end
);

    debug_pkg::byte_index_t byte_q;
    debug_pkg::word_t       word_q;
    debug_pkg::word_t       address_q;
    debug_pkg::word_t       full_word;
    logic                   loading_q;
    logic                   end_q;
    logic                   take;
    logic                   last_byte;

    assign take      = i_enable && i_rx.valid;
    assign last_byte = byte_q == debug_pkg::byte_index_t'(debug_pkg::BYTES_PER_WORD - 1);
    // Word as it stands once the top byte lands
    assign full_word = {i_rx.data, word_q[debug_pkg::WORD_WIDTH-debug_pkg::BYTE_WIDTH-1:0]};

    assign o_write       = '{loading: loading_q, instruction: word_q, address: address_q};
    assign o_program_end = end_q;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_q    <= '0;
            address_q <= '0;
            loading_q <= 1'b0;
            end_q     <= 1'b0;
        end else begin
            loading_q <= 1'b0;
            end_q     <= 1'b0;
            // Address moves on after the strobe
            if (loading_q) begin
                address_q <= address_q + 1'b1;
            end
            if (take) begin
                word_q[byte_q*debug_pkg::BYTE_WIDTH +: debug_pkg::BYTE_WIDTH] <= i_rx.data;
                byte_q <= byte_q + 1'b1;
                if (last_byte) begin
                    loading_q <= full_word != '0;
                    end_q     <= full_word == '0;
                end
            end
        end
    end

    a_load_or_end: assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_write.loading && o_program_end));

endmodule

/* source/state_dump.sv */
`timescale 1ns/1ps

module state_dump (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_dump_start,
    input  debug_pkg::cpu_state_s i_cpu,
    input  logic                  i_tx_ready,
    output debug_pkg::tx_byte_s   o_tx,
    output logic                  o_reg_send,
    output logic                  o_mem_send,
    output logic                  o_busy,
    output logic                  o_done
);

    debug_pkg::dump_phase_e phase_q;
    debug_pkg::byte_index_t byte_q;
    debug_pkg::dump_index_t word_q;
    debug_pkg::word_t       cur_word;
    logic                   reg_send_q;
    logic                   mem_send_q;
    logic                   done_q;
    logic                   accept;
    logic                   word_done;
    logic                   last_word;

    always_comb begin
        case (phase_q)
            debug_pkg::PH_PC:   cur_word = i_cpu.pc;
            debug_pkg::PH_REGS: cur_word = i_cpu.reg_word;
            default:            cur_word = i_cpu.mem_word;
        endcase
    end

    // Byte goes out whenever the transmitter is free
    assign accept    = (phase_q != debug_pkg::PH_IDLE) && i_tx_ready;
    assign word_done = accept &&
                       byte_q == debug_pkg::byte_index_t'(debug_pkg::BYTES_PER_WORD - 1);
    assign last_word = word_q == debug_pkg::dump_index_t'(debug_pkg::DUMP_WORDS - 1);

    assign o_tx = '{
        valid: accept,
        data:  cur_word[byte_q*debug_pkg::BYTE_WIDTH +: debug_pkg::BYTE_WIDTH]
    };
    assign o_reg_send = reg_send_q;
    assign o_mem_send = mem_send_q;
    assign o_busy     = phase_q != debug_pkg::PH_IDLE;
    assign o_done     = done_q;

    ////////////////////////////////////////
    // Phase sequencing
    ////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase_q    <= debug_pkg::PH_IDLE;
            byte_q     <= '0;
            word_q     <= '0;
            reg_send_q <= 1'b0;
            mem_send_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            reg_send_q <= word_done && phase_q == debug_pkg::PH_REGS;
            mem_send_q <= word_done && phase_q == debug_pkg::PH_MEM;
            done_q     <= word_done && phase_q == debug_pkg::PH_MEM && last_word;
            if (accept) begin
                byte_q <= byte_q + 1'b1;
            end
            case (phase_q)
                debug_pkg::PH_IDLE: begin
                    if (i_dump_start) begin
                        byte_q  <= '0;
                        word_q  <= '0;
                        phase_q <= debug_pkg::PH_PC;
                    end
                end
                debug_pkg::PH_PC: begin
                    if (word_done) begin
                        phase_q <= debug_pkg::PH_REGS;
                    end
                end
                debug_pkg::PH_REGS: begin
                    // Index wraps to zero for the memory words
                    if (word_done) begin
                        word_q <= word_q + 1'b1;
                        if (last_word) begin
                            phase_q <= debug_pkg::PH_MEM;
                        end
                    end
                end
                debug_pkg::PH_MEM: begin
                    if (word_done) begin
                        word_q <= word_q + 1'b1;
                        if (last_word) begin
                            phase_q <= debug_pkg::PH_IDLE;
                        end
                    end
                end
                default: phase_q <= debug_pkg::PH_IDLE;
            endcase
        end
    end

    a_start_when_idle: assert property (@(posedge i_clock) disable iff (i_reset)
        i_dump_start |-> !o_busy);

endmodule

/* source/debug_control.sv */
`timescale 1ns/1ps

module debug_control (
    input  logic                i_clock,
    input  logic                i_reset,
    input  debug_pkg::rx_byte_s i_rx,
    input  logic                i_program_end,
    input  logic                i_finish,
    input  logic                i_dump_done,
    output logic                o_load_enable,
    output logic                o_dump_start,
    output logic                o_start,
    output logic                o_step
);

    debug_pkg::control_state_e state_q;
    logic                      step_q;
    logic                      dump_start_q;

    assign o_load_enable = state_q == debug_pkg::ST_LOAD;
    assign o_dump_start  = dump_start_q;
    assign o_start       = state_q inside {debug_pkg::ST_DEBUG, debug_pkg::ST_DUMP_STEP,
                                           debug_pkg::ST_RUN};
    // Free running holds step high
    assign o_step        = step_q || state_q == debug_pkg::ST_RUN;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q      <= debug_pkg::ST_LOAD;
            step_q       <= 1'b0;
            dump_start_q <= 1'b0;
        end else begin
            step_q       <= 1'b0;
            dump_start_q <= 1'b0;
            case (state_q)
                debug_pkg::ST_LOAD: begin
                    if (i_program_end) begin
                        state_q <= debug_pkg::ST_MODE;
                    end
                end
                debug_pkg::ST_MODE: begin
                    if (i_rx.valid && i_rx.data == debug_pkg::CMD_MODE_DEBUG) begin
                        state_q <= debug_pkg::ST_DEBUG;
                    end else if (i_rx.valid && i_rx.data == debug_pkg::CMD_MODE_RUN) begin
                        state_q <= debug_pkg::ST_RUN;
                    end
                end
                debug_pkg::ST_DEBUG: begin
                    if (i_finish) begin
                        dump_start_q <= 1'b1;
                        state_q      <= debug_pkg::ST_DUMP_FINISH;
                    end else if (i_rx.valid && i_rx.data == debug_pkg::CMD_STEP) begin
                        step_q       <= 1'b1;
                        dump_start_q <= 1'b1;
                        state_q      <= debug_pkg::ST_DUMP_STEP;
                    end
                end
                debug_pkg::ST_DUMP_STEP: begin
                    if (i_dump_done) begin
                        state_q <= debug_pkg::ST_DEBUG;
                    end
                end
                debug_pkg::ST_RUN: begin
                    if (i_finish) begin
                        dump_start_q <= 1'b1;
                        state_q      <= debug_pkg::ST_DUMP_FINISH;
                    end
                end
                debug_pkg::ST_DUMP_FINISH: begin
                    // Address keeps counting into the next program
                    if (i_dump_done) begin
                        state_q <= debug_pkg::ST_LOAD;
                    end
                end
                default: state_q <= debug_pkg::ST_LOAD;
            endcase
        end
    end

    // A debug step is always a single pulse
    a_single_step: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_step && state_q != debug_pkg::ST_RUN) |=> !o_step);

endmodule

/* source/debug_unit.sv */
`timescale 1ns/1ps

module debug_unit (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_rx_data,
    input  logic             i_finish,
    input  debug_pkg::word_t i_pc,
    input  debug_pkg::word_t i_reg,
    input  debug_pkg::word_t i_mem,
    output logic             o_tx_data,
    output debug_pkg::word_t o_instruction,
    output debug_pkg::word_t o_address,
    output logic             o_loading,
    output logic             o_start,
    output logic             o_step,
    output logic             o_reg_send,
    output logic             o_mem_send
);

    debug_pkg::rx_byte_s    rx;
    debug_pkg::tx_byte_s    tx;
    debug_pkg::load_write_s write;
    debug_pkg::cpu_state_s  cpu;
    logic                   tx_ready;
    logic                   load_enable;
    logic                   program_end;
    logic                   dump_start;
    logic                   dump_done;

    assign cpu           = '{pc: i_pc, reg_word: i_reg, mem_word: i_mem};
    assign o_loading     = write.loading;
    assign o_instruction = write.instruction;
    assign o_address     = write.address;

    ////////////////////////////////////////
    // Serial side
    ////////////////////////////////////////
    uart_rx uart_rx_i (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rx_data (i_rx_data),
        .o_rx      (rx)
    );

    uart_tx uart_tx_i (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_tx      (tx),
        .o_ready   (tx_ready),
        .o_tx_data (o_tx_data)
    );

    ////////////////////////////////////////
    // Loader, control and dump
    ////////////////////////////////////////
    program_loader program_loader_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (load_enable),
        .i_rx          (rx),
        .o_write       (write),
        .o_program_end (program_end)
    );

    debug_control debug_control_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx          (rx),
        .i_program_end (program_end),
        .i_finish      (i_finish),
        .i_dump_done   (dump_done),
        .o_load_enable (load_enable),
        .o_dump_start  (dump_start),
        .o_start       (o_start),
        .o_step        (o_step)
    );

    state_dump state_dump_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_dump_start (dump_start),
        .i_cpu        (cpu),
        .i_tx_ready   (tx_ready),
        .o_tx         (tx),
        .o_reg_send   (o_reg_send),
        .o_mem_send   (o_mem_send),
        .o_busy       (),
        .o_done       (dump_done)
    );

endmodule

/* sim/debug_unit_tb.sv */
`timescale 1ns/1ps

module debug_unit_tb;

    localparam int CPB          = debug_pkg::CLOCKS_PER_BIT;
    localparam int BYTE_TIMEOUT = 20 * CPB;
    localparam int RUN_LIMIT    = 400000;

    logic             clock;
    logic             reset;
    logic             rx_data;
    logic             cpu_finish;
    debug_pkg::word_t cpu_pc;
    debug_pkg::word_t cpu_reg;
    debug_pkg::word_t cpu_mem;
    logic             tx_data;
    debug_pkg::word_t instruction;
    debug_pkg::word_t address;
    logic             loading;
    logic             start;
    logic             step;
    logic             reg_send;
    logic             mem_send;

    // Processor-side model
    debug_pkg::word_t regs [debug_pkg::DUMP_WORDS];
    debug_pkg::word_t mems [debug_pkg::DUMP_WORDS];
    int               reg_index = 0;
    int               mem_index = 0;
    int               reg_pulses = 0;
    int               mem_pulses = 0;
    int               step_pulses = 0;
    int               start_low_cycles = 0;
    debug_pkg::word_t load_data [$];
    debug_pkg::word_t load_addr [$];
    int               load_seen;
    int               next_address;
    logic [31:0]      lcg_state;

    initial clock = 1'b0;
    always #20 clock = ~clock;

    debug_unit debug_unit_i (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_rx_data     (rx_data),
        .i_finish      (cpu_finish),
        .i_pc          (cpu_pc),
        .i_reg         (cpu_reg),
        .i_mem         (cpu_mem),
        .o_tx_data     (tx_data),
        .o_instruction (instruction),
        .o_address     (address),
        .o_loading     (loading),
        .o_start       (start),
        .o_step        (step),
        .o_reg_send    (reg_send),
        .o_mem_send    (mem_send)
    );

    // Register k shows after k advance pulses
    assign cpu_reg = regs[reg_index];
    assign cpu_mem = mems[mem_index];

    always @(negedge clock) begin
        if (reg_send) begin
            reg_index  = (reg_index + 1) % debug_pkg::DUMP_WORDS;
            reg_pulses = reg_pulses + 1;
        end
        if (mem_send) begin
            mem_index  = (mem_index + 1) % debug_pkg::DUMP_WORDS;
            mem_pulses = mem_pulses + 1;
        end
        if (step) begin
            step_pulses = step_pulses + 1;
        end
        if (!start) begin
            start_low_cycles = start_low_cycles + 1;
        end
        if (loading) begin
            load_data.push_back(instruction);
            load_addr.push_back(address);
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic debug_pkg::uart_byte_t random_byte();
        logic [31:0] value;
        value = next_random();
        return value[31:24];
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                                      name, actual, expected));
        end
    endtask

    task automatic randomize_cpu_state();
        for (int k = 0; k < debug_pkg::DUMP_WORDS; k++) begin
            regs[k] = next_random();
            mems[k] = next_random();
        end
        cpu_pc = next_random();
    endtask

    ////////////////////////////////////////
    // Serial line
    ////////////////////////////////////////
    task automatic send_byte(input debug_pkg::uart_byte_t value);
        @(negedge clock);
        rx_data = 1'b0;
        repeat (CPB) @(negedge clock);
        for (int i = 0; i < debug_pkg::BYTE_WIDTH; i++) begin
            rx_data = value[i];
            repeat (CPB) @(negedge clock);
        end
        rx_data = 1'b1;
        repeat (CPB) @(negedge clock);
    endtask

    task automatic send_word(input debug_pkg::word_t word);
        for (int i = 0; i < debug_pkg::BYTES_PER_WORD; i++) begin
            send_byte(word[8*i +: 8]);
        end
    endtask

    // Samples each bit near its middle
    task automatic receive_byte(output debug_pkg::uart_byte_t value);
        int waited;
        waited = 0;
        @(negedge clock);
        while (tx_data) begin
            @(negedge clock);
            waited++;
            if (waited > BYTE_TIMEOUT) begin
                stop_on_failure("Timeout waiting for a start bit on the serial output");
            end
        end
        repeat (CPB / 2) @(negedge clock);
        if (tx_data) begin
            stop_on_failure("Start bit on the serial output ended early");
        end
        for (int i = 0; i < debug_pkg::BYTE_WIDTH; i++) begin
            repeat (CPB) @(negedge clock);
            value[i] = tx_data;
        end
        repeat (CPB) @(negedge clock);
        if (!tx_data) begin
            stop_on_failure("Stop bit missing on the serial output");
        end
    endtask

    task automatic receive_word(output debug_pkg::word_t word);
        debug_pkg::uart_byte_t value;
        for (int i = 0; i < debug_pkg::BYTES_PER_WORD; i++) begin
            receive_byte(value);
            word[8*i +: 8] = value;
        end
    endtask

    ////////////////////////////////////////
    // Scenario tasks
    ////////////////////////////////////////
    task automatic check_dump(input string label);
        debug_pkg::word_t word;
        int               reg_start;
        int               mem_start;
        reg_start = reg_pulses;
        mem_start = mem_pulses;
        receive_word(word);
        check_value($sformatf("%s pc", label), word, cpu_pc);
        for (int k = 0; k < debug_pkg::DUMP_WORDS; k++) begin
            receive_word(word);
            check_value($sformatf("%s reg %0d", label, k), word, regs[k]);
        end
        for (int k = 0; k < debug_pkg::DUMP_WORDS; k++) begin
            receive_word(word);
            check_value($sformatf("%s mem %0d", label, k), word, mems[k]);
        end
        check_value("o_reg_send pulses", reg_pulses - reg_start, debug_pkg::DUMP_WORDS);
        check_value("o_mem_send pulses", mem_pulses - mem_start, debug_pkg::DUMP_WORDS);
    endtask

    task automatic load_program(input int count);
        debug_pkg::word_t word;
        int               waited;
        for (int n = 0; n < count; n++) begin
            word = '0;
            while (word == '0) begin
                word = next_random();
            end
            send_word(word);
            waited = 0;
            while (load_data.size() <= load_seen) begin
                @(negedge clock);
                waited++;
                if (waited > BYTE_TIMEOUT) begin
                    stop_on_failure("Timeout waiting for the instruction load strobe");
                end
            end
            check_value("o_instruction", load_data[load_seen], word);
            check_value("o_address", load_addr[load_seen], next_address);
            load_seen++;
            next_address++;
        end
        // Zero word ends the program with no strobe
        send_word('0);
        repeat (2 * CPB) @(negedge clock);
        check_value("o_loading pulses", load_data.size(), load_seen);
    endtask

    task automatic pulse_finish();
        @(negedge clock);
        cpu_finish = 1'b1;
        @(negedge clock);
        cpu_finish = 1'b0;
    endtask

    initial begin
        repeat (RUN_LIMIT) @(posedge clock);
        stop_on_failure("Run time limit reached before the test finished");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        debug_pkg::uart_byte_t value;
        int                    step_before;
        int                    low_before;
        lcg_state    = 32'd56;
        load_seen    = 0;
        next_address = 0;
        reset        = 1'b1;
        rx_data      = 1'b1;
        cpu_finish   = 1'b0;
        randomize_cpu_state();
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_value("o_tx_data", 32'(tx_data), 32'd1);
        check_value("o_loading", 32'(loading), 32'd0);
        check_value("o_start", 32'(start), 32'd0);
        check_value("o_step", 32'(step), 32'd0);
        check_value("o_reg_send", 32'(reg_send), 32'd0);
        check_value("o_mem_send", 32'(mem_send), 32'd0);

        load_program(5 + int'(random_byte() % 8'd6));

        // Unknown mode bytes are ignored
        for (int n = 0; n < 4; n++) begin
            value = random_byte();
            while (value == debug_pkg::CMD_MODE_DEBUG || value == debug_pkg::CMD_MODE_RUN) begin
                value = random_byte();
            end
            send_byte(value);
            repeat (2) @(negedge clock);
            check_value("o_start", 32'(start), 32'd0);
        end
        send_byte(debug_pkg::CMD_MODE_DEBUG);
        repeat (2) @(negedge clock);
        check_value("o_start", 32'(start), 32'd1);
        check_value("o_step", 32'(step), 32'd0);

        step_before = step_pulses;
        low_before  = start_low_cycles;
        for (int n = 0; n < 3; n++) begin
            value = random_byte();
            while (value == debug_pkg::CMD_STEP) begin
                value = random_byte();
            end
            send_byte(value);
        end
        repeat (2) @(negedge clock);
        check_value("o_step pulses", step_pulses - step_before, 0);

        for (int s = 0; s < 2; s++) begin
            randomize_cpu_state();
            step_before = step_pulses;
            fork
                send_byte(debug_pkg::CMD_STEP);
                check_dump("step dump");
            join
            check_value("o_step pulses", step_pulses - step_before, 1);
        end
        check_value("o_start low cycles", start_low_cycles - low_before, 0);

        // Finish while debugging
        randomize_cpu_state();
        pulse_finish();
        check_value("o_start", 32'(start), 32'd0);
        check_dump("finish dump");

        load_program(5 + int'(random_byte() % 8'd6));
        send_byte(debug_pkg::CMD_MODE_RUN);
        repeat (2) @(negedge clock);
        check_value("o_start", 32'(start), 32'd1);
        check_value("o_step", 32'(step), 32'd1);

        randomize_cpu_state();
        pulse_finish();
        check_value("o_start", 32'(start), 32'd0);
        check_value("o_step", 32'(step), 32'd0);
        check_dump("run finish dump");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* tb.f */
source/debug_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/program_loader.sv
source/state_dump.sv
source/debug_control.sv
source/debug_unit.sv
sim/debug_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= debug_unit_tb
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_TEXT ?= CHECKS FAILED
PASS_TEXT ?= ALL CHECKS PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
